// File: fetch_frontend.f
rtl/fetch_pkg.sv
rtl/fetch_ifs.sv
rtl/redirect_unit.sv
rtl/fetch_ctrl.sv
rtl/wb_fetch_master.sv
rtl/branch_predictor.sv
rtl/inst_buffer.sv
rtl/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// File: Makefile
# Verilator flow for the fetch front end

TOP       ?= tb_fetch_frontend
FLIST     ?= fetch_frontend.f
SEED_ARGS ?=
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

# pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_fetch_frontend.sv
/*
  Testbench for the fetch front end with a Wishbone memory model.
  Every branch update sent here is a mispredict, so each one flushes
  and the reference predictor never runs ahead of the DUT.
*/
module tb_fetch_frontend
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          N_TESTS         = 5;
  localparam int          OPS_PER_TEST    = 150;
  localparam int          WATCHDOG_CYCLES = N_TESTS * OPS_PER_TEST * 40;
  localparam logic [31:0] SEED            = 32'h90f9bbf3;
  localparam vaddr_t      TRAIN_BASE      = 32'h0000_2000;
  localparam vaddr_t      MISP_BASE       = 32'h0000_3000;
  localparam vaddr_t      TRAP_BASE       = 32'h0000_4000;

  logic        i_clk;
  logic        i_reset_n;
  logic        o_wb_cyc;
  logic        o_wb_stb;
  vaddr_t      o_wb_adr;
  fetch_blk_t  i_wb_dat;
  logic        i_wb_ack;
  logic        i_br_upd_valid;
  vaddr_t      i_br_upd_pc;
  vaddr_t      i_br_upd_target;
  logic        i_br_upd_taken;
  logic        i_br_upd_mispredict;
  logic        i_commit_flush;
  except_e     i_commit_cause;
  vaddr_t      i_commit_epc;
  vaddr_t      i_csr_mepc;
  vaddr_t      i_csr_mtvec;
  vaddr_t      i_csr_stvec;
  logic [31:0] i_csr_medeleg;
  logic        o_disp_valid;
  logic        i_disp_ready;
  vaddr_t      o_disp_pc;
  inst_t       o_disp_inst;

  // reference predictor
  logic        m_btb_valid  [BTB_ENTRIES];
  vaddr_t      m_btb_pc     [BTB_ENTRIES];
  vaddr_t      m_btb_target [BTB_ENTRIES];
  bim_ctr_t    m_bim        [BIM_ENTRIES];

  logic [31:0] rng;
  int          errors;
  int          disp_cnt;
  int          total_disp;
  vaddr_t      exp_pc;
  logic        stall_last;
  logic        flushed_last;
  vaddr_t      held_pc;
  inst_t       held_inst;
  logic        bus_busy;
  logic        bus_acked;
  vaddr_t      bus_adr;
  int          bus_wait;
  int          train_state;
  vaddr_t      train_pc;
  int          loop_hits;
  string       names [N_TESTS] = '{"straight", "backpressure", "training", "mispredict", "commit"};

  fetch_frontend dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] rand_bits();
    rng = rng * 32'd1664525 + 32'd1013904223;
    // low LCG bits are weak
    return {8'h00, rng[31:8]};
  endfunction

  function automatic inst_t mem_word(input vaddr_t a);
    return (a * 32'h9e37) ^ 32'h13;
  endfunction

  function automatic vaddr_t window_addr(input vaddr_t base);
    return base + vaddr_t'(4 * (rand_bits() % 32));
  endfunction

  function automatic int btb_slot(input vaddr_t pc);
    return int'((pc >> 2) % BTB_ENTRIES);
  endfunction

  function automatic int bim_slot(input vaddr_t pc);
    return int'((pc >> 2) % BIM_ENTRIES);
  endfunction

  function automatic logic predicted_taken(input vaddr_t pc);
    int b;
    b = btb_slot(pc);
    return m_btb_valid[b] && ((m_btb_pc[b] >> 2) / BTB_ENTRIES == (pc >> 2) / BTB_ENTRIES) &&
           (m_bim[bim_slot(pc)] >= 2'd2);
  endfunction

  function automatic except_e pick_cause(input int n);
    case (n)
      0:       return INST_ADDR_MISALIGN;
      1:       return INST_ACC_FAULT;
      2:       return ILLEGAL_INST;
      3:       return ECALL_U;
      4:       return ECALL_S;
      5:       return ECALL_M;
      6:       return INST_PAGE_FAULT;
      7:       return SILENT_FLUSH;
      default: return MRET;
    endcase
  endfunction

  function automatic vaddr_t commit_target(input except_e c, input vaddr_t epc,
                                           input vaddr_t mepc, input vaddr_t mtvec,
                                           input vaddr_t stvec, input logic [31:0] deleg);
    case (c)
      SILENT_FLUSH: return epc + 32'd4;
      MRET:         return mepc;
      default:      return deleg[c] ? stvec : mtvec;
    endcase
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_pc(input string what, input vaddr_t got, input vaddr_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input string what, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // drives a mispredicting update and trains the reference copy
  task automatic send_branch(input vaddr_t pc, input vaddr_t target, input logic taken);
    int c;
    c = bim_slot(pc);
    i_br_upd_valid      = 1'b1;
    i_br_upd_pc         = pc;
    i_br_upd_target     = target;
    i_br_upd_taken      = taken;
    i_br_upd_mispredict = 1'b1;
    if (taken) begin
      if (m_bim[c] != 2'd3) m_bim[c] = m_bim[c] + 2'd1;
      m_btb_valid[btb_slot(pc)]  = 1'b1;
      m_btb_pc[btb_slot(pc)]     = pc;
      m_btb_target[btb_slot(pc)] = target;
    end else if (m_bim[c] != 2'd0) begin
      m_bim[c] = m_bim[c] - 2'd1;
    end
  endtask

  // ====================
  // wishbone memory
  // ====================
  task automatic serve_bus();
    if (bus_acked) begin
      i_wb_ack  = 1'b0;
      bus_acked = 1'b0;
      if (o_wb_cyc) note_failure("wishbone cyc stayed high after ack");
    end else if (o_wb_cyc) begin
      if (!o_wb_stb) note_failure("wishbone cyc high without stb");
      if (!bus_busy) begin
        bus_busy = 1'b1;
        bus_adr  = o_wb_adr;
        bus_wait = int'(rand_bits() % 4);
        if (o_wb_adr % FETCH_BYTES != 0) note_failure("wishbone address not block aligned");
      end else begin
        check_pc("wishbone address held", o_wb_adr, bus_adr);
      end
      if (bus_wait == 0) begin
        i_wb_ack  = 1'b1;
        i_wb_dat  = {mem_word(bus_adr + 32'd4), mem_word(bus_adr)};
        bus_acked = 1'b1;
        bus_busy  = 1'b0;
      end else begin
        bus_wait--;
      end
    end else if (o_wb_stb) begin
      note_failure("wishbone stb high without cyc");
    end
  endtask

  // ====================
  // one cycle of stimulus and checking
  // ====================
  task automatic step(input int test_id);
    logic    flush_now;
    vaddr_t  target;
    vaddr_t  pc;
    logic    take;
    except_e cause;
    flush_now = 1'b0;
    target    = '0;
    @(negedge i_clk);
    serve_bus();

    // outputs left by the last edge
    if (flushed_last && o_disp_valid) note_failure("dispatch valid right after a flush");
    if (stall_last) begin
      if (!o_disp_valid) begin
        note_failure("dispatch valid dropped while ready was low");
      end else begin
        check_pc("stalled pc", o_disp_pc, held_pc);
        check_inst("stalled inst", o_disp_inst, held_inst);
      end
    end

    i_br_upd_valid      = 1'b0;
    i_br_upd_mispredict = 1'b0;
    i_commit_flush      = 1'b0;
    if (test_id == 0) i_disp_ready = 1'b1;
    else if (test_id == 1) i_disp_ready = rand_bits() % 2 != 0;
    else i_disp_ready = rand_bits() % 4 != 0;

    case (test_id)
      2: begin
        if (train_state == 0) begin
          // backward branch forms a loop once trained
          send_branch(train_pc, TRAIN_BASE, 1'b1);
          target      = TRAIN_BASE;
          flush_now   = 1'b1;
          train_state = 1;
        end else if (train_state == 1 && disp_cnt >= OPS_PER_TEST / 2) begin
          send_branch(train_pc, train_pc + 32'd4, 1'b0);
          target      = train_pc + 32'd4;
          flush_now   = 1'b1;
          train_state = 2;
        end else if (train_state == 2 && disp_cnt >= OPS_PER_TEST * 3 / 4) begin
          // re-enter the loop body so the weakened branch falls through
          i_commit_flush = 1'b1;
          i_commit_cause = SILENT_FLUSH;
          i_commit_epc   = TRAIN_BASE - 32'd4;
          target         = commit_target(SILENT_FLUSH, i_commit_epc, i_csr_mepc, i_csr_mtvec,
                                         i_csr_stvec, i_csr_medeleg);
          flush_now      = 1'b1;
          train_state    = 3;
        end
      end
      3: begin
        if (rand_bits() % 16 == 0) begin
          pc     = window_addr(MISP_BASE);
          take   = rand_bits() % 2 != 0;
          target = take ? window_addr(MISP_BASE) : pc + 32'd4;
          send_branch(pc, target, take);
          flush_now = 1'b1;
        end
      end
      4: begin
        if (rand_bits() % 16 == 0) begin
          cause          = pick_cause(int'(rand_bits() % 9));
          i_commit_flush = 1'b1;
          i_commit_cause = cause;
          i_commit_epc   = window_addr(TRAP_BASE);
          i_csr_mepc     = window_addr(TRAP_BASE);
          i_csr_mtvec    = window_addr(TRAP_BASE);
          i_csr_stvec    = window_addr(TRAP_BASE);
          i_csr_medeleg  = rand_bits();
          // branch update in the same cycle loses to the commit
          if (rand_bits() % 4 == 0) begin
            pc   = window_addr(MISP_BASE);
            take = rand_bits() % 2 != 0;
            send_branch(pc, take ? window_addr(MISP_BASE) : pc + 32'd4, take);
          end
          target    = commit_target(cause, i_commit_epc, i_csr_mepc, i_csr_mtvec,
                                    i_csr_stvec, i_csr_medeleg);
          flush_now = 1'b1;
        end
      end
      default: ;
    endcase

    // a flush in the same cycle cancels the handshake
    if (!flush_now && o_disp_valid && i_disp_ready) begin
      check_pc("dispatch pc", o_disp_pc, exp_pc);
      check_inst("dispatch inst", o_disp_inst, mem_word(exp_pc));
      if (test_id == 2 && train_state == 1 && o_disp_pc == train_pc) loop_hits++;
      exp_pc = predicted_taken(exp_pc) ? m_btb_target[btb_slot(exp_pc)] : exp_pc + 32'd4;
      disp_cnt++;
      total_disp++;
    end
    if (flush_now) exp_pc = target;
    stall_last   = !flush_now && o_disp_valid && !i_disp_ready;
    held_pc      = o_disp_pc;
    held_inst    = o_disp_inst;
    flushed_last = flush_now;
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int err_start;
    int tests_ok;
    i_reset_n           = 1'b0;
    i_wb_dat            = '0;
    i_wb_ack            = 1'b0;
    i_br_upd_valid      = 1'b0;
    i_br_upd_pc         = '0;
    i_br_upd_target     = '0;
    i_br_upd_taken      = 1'b0;
    i_br_upd_mispredict = 1'b0;
    i_commit_flush      = 1'b0;
    i_commit_cause      = SILENT_FLUSH;
    i_commit_epc        = '0;
    i_csr_mepc          = '0;
    i_csr_mtvec         = '0;
    i_csr_stvec         = '0;
    i_csr_medeleg       = '0;
    i_disp_ready        = 1'b0;
    rng                 = SEED;
    errors              = 0;
    total_disp          = 0;
    tests_ok            = 0;
    exp_pc              = PC_RESET;
    stall_last          = 1'b0;
    flushed_last        = 1'b0;
    bus_busy            = 1'b0;
    bus_acked           = 1'b0;
    bus_wait            = 0;
    for (int i = 0; i < BTB_ENTRIES; i++) m_btb_valid[i] = 1'b0;
    for (int i = 0; i < BIM_ENTRIES; i++) m_bim[i] = 2'd1;

    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    for (int t = 0; t < N_TESTS; t++) begin
      err_start   = errors;
      disp_cnt    = 0;
      train_state = 0;
      loop_hits   = 0;
      train_pc    = TRAIN_BASE + vaddr_t'(4 * (1 + rand_bits() % 14));
      while (disp_cnt < OPS_PER_TEST) step(t);
      if (t == 2 && loop_hits < 2) begin
        note_failure($sformatf("trained branch at %h did not loop back", train_pc));
      end
      if (errors == err_start) tests_ok++;
      $display("%s: %s, %0d instructions, %0d errors", names[t],
               (errors == err_start) ? "PASS" : "FAIL", disp_cnt, errors - err_start);
    end

    $display("summary: %0d of %0d tests ok, %0d errors, %0d instructions checked",
             tests_ok, N_TESTS, errors, total_disp);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("ERROR: watchdog expired after %0d cycles, dispatch stalled", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// File: rtl/fetch_frontend.sv
/*
  Instruction fetch front end, Wishbone classic read master.
  Branch updates must already be filtered for dead branches.
*/
module fetch_frontend
  import fetch_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  // wishbone classic master, read only
  output logic        o_wb_cyc,
  output logic        o_wb_stb,
  output vaddr_t      o_wb_adr,
  input  fetch_blk_t  i_wb_dat,
  input  logic        i_wb_ack,
  // branch resolution
  input  logic        i_br_upd_valid,
  input  vaddr_t      i_br_upd_pc,
  input  vaddr_t      i_br_upd_target,
  input  logic        i_br_upd_taken,
  input  logic        i_br_upd_mispredict,
  // commit
  input  logic        i_commit_flush,
  input  except_e     i_commit_cause,
  input  vaddr_t      i_commit_epc,
  // csr
  input  vaddr_t      i_csr_mepc,
  input  vaddr_t      i_csr_mtvec,
  input  vaddr_t      i_csr_stvec,
  input  logic [31:0] i_csr_medeleg,
  // dispatch
  output logic        o_disp_valid,
  input  logic        i_disp_ready,
  output vaddr_t      o_disp_pc,
  output inst_t       o_disp_inst
);

  logic       w_flush;
  vaddr_t     w_flush_pc;
  logic       w_req;
  vaddr_t     w_req_adr;
  logic       w_rsp_valid;
  fetch_blk_t w_rsp_data;
  logic       w_push;
  vaddr_t     w_push_pc;
  fetch_blk_t w_push_data;
  slot_mask_t w_push_mask;
  logic       w_ibuf_ready;

  bp_search_if w_bp_search ();
  bp_update_if w_bp_update ();

  redirect_unit u_redirect (
    .i_commit_flush      (i_commit_flush),
    .i_commit_cause      (i_commit_cause),
    .i_commit_epc        (i_commit_epc),
    .i_csr_mepc          (i_csr_mepc),
    .i_csr_mtvec         (i_csr_mtvec),
    .i_csr_stvec         (i_csr_stvec),
    .i_csr_medeleg       (i_csr_medeleg),
    .i_br_upd_valid      (i_br_upd_valid),
    .i_br_upd_pc         (i_br_upd_pc),
    .i_br_upd_target     (i_br_upd_target),
    .i_br_upd_taken      (i_br_upd_taken),
    .i_br_upd_mispredict (i_br_upd_mispredict),
    .o_flush             (w_flush),
    .o_flush_pc          (w_flush_pc),
    .bp_update           (w_bp_update)
  );

  fetch_ctrl u_fetch_ctrl (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_flush),
    .i_flush_pc   (w_flush_pc),
    .i_rsp_valid  (w_rsp_valid),
    .i_rsp_data   (w_rsp_data),
    .i_ibuf_ready (w_ibuf_ready),
    .o_req        (w_req),
    .o_req_adr    (w_req_adr),
    .o_push       (w_push),
    .o_push_pc    (w_push_pc),
    .o_push_data  (w_push_data),
    .o_push_mask  (w_push_mask),
    .bp_search    (w_bp_search)
  );

  wb_fetch_master u_wb_master (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req       (w_req),
    .i_req_adr   (w_req_adr),
    .i_wb_dat    (i_wb_dat),
    .i_wb_ack    (i_wb_ack),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_adr    (o_wb_adr),
    .o_rsp_valid (w_rsp_valid),
    .o_rsp_data  (w_rsp_data)
  );

  branch_predictor u_predictor (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .search    (w_bp_search),
    .update    (w_bp_update)
  );

  inst_buffer u_ibuf (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_flush),
    .i_push       (w_push),
    .i_push_pc    (w_push_pc),
    .i_push_data  (w_push_data),
    .i_push_mask  (w_push_mask),
    .i_disp_ready (i_disp_ready),
    .o_ready      (w_ibuf_ready),
    .o_disp_valid (o_disp_valid),
    .o_disp_pc    (o_disp_pc),
    .o_disp_inst  (o_disp_inst)
  );

endmodule

// File: rtl/inst_buffer.sv
/*
  Block FIFO, one instruction out per handshake.
  Pushed masks must have at least one slot set.
*/
module inst_buffer
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_flush,
  input  logic       i_push,
  input  vaddr_t     i_push_pc,
  input  fetch_blk_t i_push_data,
  input  slot_mask_t i_push_mask,
  input  logic       i_disp_ready,
  output logic       o_ready,
  output logic       o_disp_valid,
  output vaddr_t     o_disp_pc,
  output inst_t      o_disp_inst
);

  vaddr_t                    r_pc   [IBUF_DEPTH];
  fetch_blk_t                r_data [IBUF_DEPTH];
  slot_mask_t                r_mask [IBUF_DEPTH];
  logic [IBUF_PTR_W-1:0]     r_wr;
  logic [IBUF_PTR_W-1:0]     r_rd;
  logic [IBUF_PTR_W:0]       r_count;
  slot_mask_t                r_used;
  slot_mask_t                w_avail;
  slot_mask_t                w_slot_oh;
  logic [SLOT_W-1:0]         w_slot;
  logic                      w_push;
  logic                      w_pop;
  logic                      w_blk_done;

  assign o_ready      = (r_count != (IBUF_PTR_W + 1)'(IBUF_DEPTH));
  assign o_disp_valid = (r_count != '0);
  assign w_push       = i_push & o_ready;

  // lowest slot of the head block not yet handed out
  always_comb begin
    w_avail = r_mask[r_rd] & ~r_used;
    w_slot  = '0;
    for (int i = FETCH_SLOTS - 1; i >= 0; i--) begin
      if (w_avail[i]) w_slot = SLOT_W'(i);
    end
  end

  assign w_slot_oh   = slot_mask_t'(1) << w_slot;
  assign w_pop       = o_disp_valid & i_disp_ready;
  assign w_blk_done  = w_pop & ((w_avail & ~w_slot_oh) == '0);
  assign o_disp_pc   = r_pc[r_rd] + (vaddr_t'(w_slot) << 2);
  assign o_disp_inst = r_data[r_rd][w_slot * INST_W +: INST_W];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr    <= '0;
      r_rd    <= '0;
      r_count <= '0;
      r_used  <= '0;
    end else if (i_flush) begin
      r_wr    <= '0;
      r_rd    <= '0;
      r_count <= '0;
      r_used  <= '0;
    end else begin
      if (w_push) r_wr <= r_wr + 1'b1;
      if (w_blk_done) begin
        r_rd   <= r_rd + 1'b1;
        r_used <= '0;
      end else if (w_pop) begin
        r_used <= r_used | w_slot_oh;
      end
      r_count <= r_count + (IBUF_PTR_W + 1)'(w_push) - (IBUF_PTR_W + 1)'(w_blk_done);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push && !i_flush) begin
      r_pc[r_wr]   <= i_push_pc;
      r_data[r_wr] <= i_push_data;
      r_mask[r_wr] <= i_push_mask;
    end
  end

endmodule

// File: rtl/branch_predictor.sv
/*
  Direct-mapped BTB plus bimodal counters, both slots searched at once.
  BTB entries are only written by taken mispredicts, never evicted.
*/
module branch_predictor
  import fetch_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  bp_search_if.pred search,
  bp_update_if.pred update
);

  logic [BTB_ENTRIES-1:0] r_btb_valid;
  logic [BTB_TAG_W-1:0]   r_btb_tag    [BTB_ENTRIES];
  vaddr_t                 r_btb_target [BTB_ENTRIES];
  bim_ctr_t               r_bim        [BIM_ENTRIES];
  vaddr_t                 w_slot_pc    [FETCH_SLOTS];
  slot_mask_t             w_pred_taken;
  bim_ctr_t               w_ctr_cur;
  bim_ctr_t               w_ctr_next;
  logic                   w_btb_write;

  function automatic logic [BTB_IDX_W-1:0] btb_idx(input vaddr_t pc);
    return pc[BTB_IDX_W+1:2];
  endfunction

  function automatic logic [BTB_TAG_W-1:0] btb_tag(input vaddr_t pc);
    return pc[VADDR_W-1:BTB_IDX_W+2];
  endfunction

  function automatic logic [BIM_IDX_W-1:0] bim_idx(input vaddr_t pc);
    return pc[BIM_IDX_W+1:2];
  endfunction

  // ====================
  // search
  // ====================
  always_comb begin
    for (int i = 0; i < FETCH_SLOTS; i++) begin
      w_slot_pc[i] = {search.s0_pc[VADDR_W-1:OFFSET_W], OFFSET_W'(0)} + vaddr_t'(4 * i);
      w_pred_taken[i] = r_btb_valid[btb_idx(w_slot_pc[i])] &
                        (r_btb_tag[btb_idx(w_slot_pc[i])] == btb_tag(w_slot_pc[i])) &
                        (r_bim[bim_idx(w_slot_pc[i])] >= 2'd2);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      search.s1_taken <= '0;
    end else if (search.s0_valid) begin
      search.s1_taken <= w_pred_taken;
    end
  end

  always_ff @(posedge i_clk) begin
    if (search.s0_valid) begin
      for (int i = 0; i < FETCH_SLOTS; i++) begin
        search.s1_target[i] <= r_btb_target[btb_idx(w_slot_pc[i])];
      end
    end
  end

  // ====================
  // training
  // ====================
  assign w_btb_write = update.valid & update.mispredict & update.taken;
  assign w_ctr_cur   = r_bim[bim_idx(update.pc)];

  always_comb begin
    w_ctr_next = w_ctr_cur;
    if (update.taken) begin
      if (w_ctr_cur != 2'd3) w_ctr_next = w_ctr_cur + 2'd1;
    end else if (w_ctr_cur != 2'd0) begin
      w_ctr_next = w_ctr_cur - 2'd1;
    end
  end

  // counters start weakly not taken
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_btb_valid <= '0;
      for (int i = 0; i < BIM_ENTRIES; i++) r_bim[i] <= 2'd1;
    end else begin
      if (w_btb_write) r_btb_valid[btb_idx(update.pc)] <= 1'b1;
      if (update.valid) r_bim[bim_idx(update.pc)] <= w_ctr_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_btb_write) begin
      r_btb_tag[btb_idx(update.pc)]    <= btb_tag(update.pc);
      r_btb_target[btb_idx(update.pc)] <= update.target;
    end
  end

endmodule

// File: rtl/wb_fetch_master.sv
/*
  Wishbone classic single read, one transfer at a time.
  A request arriving while a cycle is open is ignored.
*/
module wb_fetch_master
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_req,
  input  vaddr_t     i_req_adr,
  input  fetch_blk_t i_wb_dat,
  input  logic       i_wb_ack,
  output logic       o_wb_cyc,
  output logic       o_wb_stb,
  output vaddr_t     o_wb_adr,
  output logic       o_rsp_valid,
  output fetch_blk_t o_rsp_data
);

  logic r_cyc;

  // cyc and stb move together for a single transfer
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cyc       <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= r_cyc & i_wb_ack;
      if (r_cyc) begin
        if (i_wb_ack) r_cyc <= 1'b0;
      end else if (i_req) begin
        r_cyc <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!r_cyc && i_req) o_wb_adr <= i_req_adr;
    if (r_cyc && i_wb_ack) o_rsp_data <= i_wb_dat;
  end

  assign o_wb_cyc = r_cyc;
  assign o_wb_stb = r_cyc;

endmodule

// File: rtl/fetch_ctrl.sv
/*
  Fetch FSM, one block in flight at a time.
  Flush targets are assumed 4-byte aligned.
  Predictor results are consumed while still held from the last search.
*/
module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_flush,
  input  vaddr_t     i_flush_pc,
  input  logic       i_rsp_valid,
  input  fetch_blk_t i_rsp_data,
  input  logic       i_ibuf_ready,
  output logic       o_req,
  output vaddr_t     o_req_adr,
  output logic       o_push,
  output vaddr_t     o_push_pc,
  output fetch_blk_t o_push_data,
  output slot_mask_t o_push_mask,
  bp_search_if.fetch bp_search
);

  fetch_state_e r_state;
  fetch_state_e w_state_next;
  vaddr_t       r_pc;
  vaddr_t       w_pc_next;
  vaddr_t       w_blk_adr;
  vaddr_t       w_pred_pc;
  slot_mask_t   w_mask;
  fetch_blk_t   r_hold_data;
  logic         r_live;
  logic         w_issue;
  logic         w_have_rsp;

  // ====================
  // issue
  // ====================
  assign w_blk_adr = {r_pc[VADDR_W-1:OFFSET_W], OFFSET_W'(0)};
  // idle for one cycle after reset
  assign w_issue   = (r_state == S_ISSUE) & r_live & ~i_flush;

  assign o_req              = w_issue;
  assign o_req_adr          = w_blk_adr;
  assign bp_search.s0_valid = w_issue;
  assign bp_search.s0_pc    = r_pc;

  // ====================
  // slot mask, next pc
  // ====================
  always_comb begin
    logic stop;
    stop      = 1'b0;
    w_mask    = '0;
    w_pred_pc = w_blk_adr + vaddr_t'(FETCH_BYTES);
    for (int i = 0; i < FETCH_SLOTS; i++) begin
      if (!stop && (i >= int'(r_pc[OFFSET_W-1:2]))) begin
        w_mask[i] = 1'b1;
        // first taken slot ends the block
        if (bp_search.s1_taken[i]) begin
          stop      = 1'b1;
          w_pred_pc = bp_search.s1_target[i];
        end
      end
    end
  end

  assign w_have_rsp  = ((r_state == S_BUS) & i_rsp_valid) | (r_state == S_IBUF);
  assign o_push      = w_have_rsp & i_ibuf_ready & ~i_flush;
  assign o_push_pc   = w_blk_adr;
  assign o_push_data = (r_state == S_IBUF) ? r_hold_data : i_rsp_data;
  assign o_push_mask = w_mask;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      S_ISSUE: if (w_issue) w_state_next = S_BUS;
      S_BUS: begin
        if (i_flush) begin
          // open cycle must still finish
          w_state_next = i_rsp_valid ? S_ISSUE : S_DRAIN;
        end else if (i_rsp_valid) begin
          w_state_next = i_ibuf_ready ? S_ISSUE : S_IBUF;
        end
      end
      S_DRAIN: if (i_rsp_valid) w_state_next = S_ISSUE;
      S_IBUF:  if (i_flush || i_ibuf_ready) w_state_next = S_ISSUE;
      default: w_state_next = S_ISSUE;
    endcase
  end

  assign w_pc_next = i_flush ? i_flush_pc : (o_push ? w_pred_pc : r_pc);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= S_ISSUE;
      r_pc    <= PC_RESET;
      r_live  <= 1'b0;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
      r_live  <= 1'b1;
    end
  end

  // response parked while the buffer is full
  always_ff @(posedge i_clk) begin
    if ((r_state == S_BUS) && i_rsp_valid) begin
      r_hold_data <= i_rsp_data;
    end
  end

endmodule

// File: rtl/redirect_unit.sv
/*
  Flush decision and target, purely combinational.
  Commit flush has priority over a branch mispredict in the same cycle.
*/
module redirect_unit
  import fetch_pkg::*;
(
  input  logic        i_commit_flush,
  input  except_e     i_commit_cause,
  input  vaddr_t      i_commit_epc,
  input  vaddr_t      i_csr_mepc,
  input  vaddr_t      i_csr_mtvec,
  input  vaddr_t      i_csr_stvec,
  input  logic [31:0] i_csr_medeleg,
  input  logic        i_br_upd_valid,
  input  vaddr_t      i_br_upd_pc,
  input  vaddr_t      i_br_upd_target,
  input  logic        i_br_upd_taken,
  input  logic        i_br_upd_mispredict,
  output logic        o_flush,
  output vaddr_t      o_flush_pc,
  bp_update_if.backend bp_update
);

  logic w_br_flush;

  assign w_br_flush = i_br_upd_valid & i_br_upd_mispredict;
  assign o_flush    = i_commit_flush | w_br_flush;

  always_comb begin
    if (i_commit_flush) begin
      case (i_commit_cause)
        SILENT_FLUSH: o_flush_pc = i_commit_epc + vaddr_t'(4);
        MRET:         o_flush_pc = i_csr_mepc;
        // trap, delegated ones go to the supervisor vector
        default:      o_flush_pc = i_csr_medeleg[i_commit_cause] ? i_csr_stvec : i_csr_mtvec;
      endcase
    end else begin
      o_flush_pc = i_br_upd_target;
    end
  end

  // every resolved branch trains the predictor
  assign bp_update.valid      = i_br_upd_valid;
  assign bp_update.pc         = i_br_upd_pc;
  assign bp_update.target     = i_br_upd_target;
  assign bp_update.taken      = i_br_upd_taken;
  assign bp_update.mispredict = i_br_upd_mispredict;

endmodule

// File: rtl/fetch_ifs.sv
/*
  Predictor search and update links.
  Search results are registered one cycle after s0_valid and held
  until the next search.
*/

// ====================
// search
// ====================
interface bp_search_if
  import fetch_pkg::*;
();

  logic                         s0_valid;
  vaddr_t                       s0_pc;
  slot_mask_t                   s1_taken;
  vaddr_t [FETCH_SLOTS-1:0]     s1_target;

  modport fetch (
    output s0_valid, s0_pc,
    input  s1_taken, s1_target
  );

  modport pred (
    input  s0_valid, s0_pc,
    output s1_taken, s1_target
  );

endinterface

// ====================
// update
// ====================
interface bp_update_if
  import fetch_pkg::*;
();

  logic   valid;
  vaddr_t pc;
  vaddr_t target;
  logic   taken;
  logic   mispredict;

  modport backend (output valid, pc, target, taken, mispredict);
  modport pred    (input  valid, pc, target, taken, mispredict);

endinterface

// File: rtl/fetch_pkg.sv
/*
  Shared widths, types and encodings of the fetch front end.
  Fetch blocks are 8 bytes, two 32-bit slots, slot 0 in the low half.
  Commit causes above 15 are internal and never index medeleg.
*/
package fetch_pkg;

  // ====================
  // sizes
  // ====================
  localparam int VADDR_W     = 32;
  localparam int INST_W      = 32;
  localparam int FETCH_SLOTS = 2;
  localparam int FETCH_BYTES = 8;
  localparam int FETCH_W     = 64;
  localparam int BTB_ENTRIES = 16;
  localparam int BIM_ENTRIES = 64;
  localparam int IBUF_DEPTH  = 4;

  // derived index widths
  localparam int OFFSET_W   = $clog2(FETCH_BYTES);
  localparam int SLOT_W     = $clog2(FETCH_SLOTS);
  localparam int BTB_IDX_W  = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W  = VADDR_W - BTB_IDX_W - 2;
  localparam int BIM_IDX_W  = $clog2(BIM_ENTRIES);
  localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);

  // ====================
  // types
  // ====================
  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [INST_W-1:0]      inst_t;
  typedef logic [FETCH_W-1:0]     fetch_blk_t;
  typedef logic [FETCH_SLOTS-1:0] slot_mask_t;
  typedef logic [1:0]             bim_ctr_t;

  localparam vaddr_t PC_RESET = 32'h0000_1000;

  // standard cause numbers, internal flush kinds above 15
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN = 5'd0,
    INST_ACC_FAULT     = 5'd1,
    ILLEGAL_INST       = 5'd2,
    ECALL_U            = 5'd8,
    ECALL_S            = 5'd9,
    ECALL_M            = 5'd11,
    INST_PAGE_FAULT    = 5'd12,
    SILENT_FLUSH       = 5'd16,
    MRET               = 5'd17
  } except_e;

  typedef enum logic [1:0] {
    S_ISSUE = 2'd0,
    S_BUS   = 2'd1,
    S_DRAIN = 2'd2,
    S_IBUF  = 2'd3
  } fetch_state_e;

endpackage
